// File: compile.f
design/scope_pkg.sv
design/acq_ctrl_if.sv
design/sample_conditioner.sv
design/cmd_decoder.sv
design/trigger_engine.sv
design/scope_ctrl_top.sv
verif/tb_scope_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f \
	--top-module tb_scope_ctrl -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/Vtb_scope_ctrl); then
	echo "$out"
	echo "simulation exited with an error"
	exit 1
fi
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

// File: verif/tb_scope_ctrl.sv
// scope control core testbench
// drives command bytes, adc words and the external trigger, checks replies and trigger pulses
`timescale 1ns/10ps

module tb_scope_ctrl;

	localparam int CLK_PERIOD  = 8;
	localparam int NUM_TESTS   = 6;
	localparam int MAX_POST    = 32;                   // longest post length used below
	localparam int MARGIN      = 100;
	localparam int WATCHDOG_NS = NUM_TESTS * MAX_POST * MARGIN * CLK_PERIOD;

	logic         clk;
	logic         rstn;
	logic         i_rx_tvalid;
	logic [7:0]   i_rx_tdata;
	logic         o_rx_tready;
	logic         o_tx_tvalid;
	logic [31:0]  o_tx_tdata;
	logic [3:0]   o_tx_tkeep;
	logic         o_tx_tlast;
	logic         i_tx_tready;
	logic [239:0] i_raw_samples;
	logic         i_ext_trig;
	logic         o_trig_out;

	int errors    = 0;
	int ev        = 0;                                 // expected event count
	int trig_cnt  = 0;                                 // trigger-out pulses seen

	scope_ctrl_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk) if (o_trig_out) trig_cnt <= trig_cnt + 1;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	// ------------------------------
	// reference model

	// level and hysteresis bytes onto the 12-bit adc scale
	function automatic logic signed [11:0] thr_calc(input int level, input int hyst,
		input bit upper);
		int v;
		v = (level + (upper ? hyst : -hyst) - 128) * 16 + 8;
		return v[11:0];
	endfunction

	// ch0 always inverted, ch1 only in single mode, -2048 clamps to +2047
	function automatic logic signed [11:0] cond_calc(input logic signed [11:0] raw,
		input int lane, input bit dual);
		if (lane >= 10 && dual) return raw;
		if (raw == 12'sh800) return 12'sh7ff;
		return -raw;
	endfunction

	// per sample trigger condition on one channel
	function automatic logic [9:0] qual_mask(input logic [239:0] raw, input bit dual,
		input bit chan, input logic signed [11:0] thr, input bit below);
		logic [9:0]          m;
		logic signed [11:0]  c;
		int                  lane;
		m = '0;
		for (int i = 0; i < 10; i++) begin
			lane = (chan ? 10 : 0) + i;
			c    = cond_calc(raw[12*lane +: 12], lane, dual);
			m[i] = below ? (c < thr) : (c > thr);
		end
		return m;
	endfunction

	function automatic logic [31:0] status_word(input logic [7:0] evc, input logic [15:0] hit,
		input logic [7:0] st);
		scope_pkg::reply_word_u w;
		w.status.event_count = evc;
		w.status.sample_hit  = hit;
		w.status.acq_state   = st;
		return w.raw;
	endfunction

	function automatic logic [239:0] fill_lanes(input logic signed [11:0] base,
		input logic signed [11:0] hit, input logic [19:0] mask);
		logic [239:0] v;
		for (int i = 0; i < 20; i++) v[12*i +: 12] = mask[i] ? hit : base;
		return v;
	endfunction

	// ------------------------------
	// stimulus and reply tasks
	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
	endtask

	task automatic send_cmd(input logic [63:0] cmd);      // byte 0 in the low bits
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			i_rx_tvalid = 1'b1;
			i_rx_tdata  = cmd[8*i +: 8];
			while (!o_rx_tready) @(negedge clk);           // taken on the next rising edge
		end
		@(negedge clk);
		i_rx_tvalid = 1'b0;
	endtask

	task automatic recv_reply(input string name, output logic [31:0] data);
		logic [31:0] held;
		bit          seen;
		bit          done;
		int          waited;
		seen   = 0;
		done   = 0;
		waited = 0;
		data   = '0;
		while (!done) begin
			@(negedge clk);
			i_tx_tready = 1'($urandom_range(1, 0));        // random back-pressure
			if (o_tx_tvalid) begin
				if (seen && o_tx_tdata !== held) report_mismatch({name, " hold"}, held, o_tx_tdata);
				if (o_tx_tkeep !== 4'hf) report_mismatch({name, " keep"}, 32'hf, 32'(o_tx_tkeep));
				if (o_tx_tlast !== 1'b1) report_mismatch({name, " last"}, 32'd1, 32'(o_tx_tlast));
				held = o_tx_tdata;
				seen = 1;
				if (i_tx_tready) begin
					data = o_tx_tdata;
					done = 1;
				end
			end
			waited++;
			if (!done && waited > 200) begin
				errors++;
				$display("%s: no reply beat within 200 cycles", name);
				done = 1;
			end
		end
		@(negedge clk);
		i_tx_tready = 1'b0;
	endtask

	task automatic arm_cmd(input string name, input logic [7:0] ttype, input bit dual,
		input logic [15:0] post, input logic [7:0] exp_state);
		scope_pkg::reply_word_u rw;
		logic [31:0]            rep;
		send_cmd({16'd0, post, 8'd0, 7'd0, dual, ttype, scope_pkg::CMD_ARM});
		recv_reply(name, rep);
		rw.raw = rep;
		if (rw.status.acq_state !== exp_state) report_mismatch(name, exp_state, rw.status.acq_state);
	endtask

	task automatic set_trig(input string name, input logic [7:0] level, input logic [7:0] hyst,
		input logic [7:0] tot, input bit chan);
		logic [31:0] rep;
		send_cmd({8'd0, 7'd0, chan, tot, 16'd0, hyst, level, scope_pkg::CMD_TRIG_SET});
		recv_reply(name, rep);
		if (rep !== 32'd8) report_mismatch(name, 32'd8, rep);   // echoes its code
	endtask

	task automatic ack_check(input string name, input logic [31:0] exp);
		logic [31:0] rep;
		send_cmd({56'd0, scope_pkg::CMD_ACK});
		recv_reply(name, rep);
		if (rep !== exp) report_mismatch(name, exp, rep);
	endtask

	// ack polls, the one that sees done also sends the engine back to ready
	task automatic poll_done(input string name, input logic [31:0] exp);
		scope_pkg::reply_word_u rw;
		logic [31:0]            rep;
		int                     polls;
		polls  = 0;
		rw.raw = '0;
		while (rw.status.acq_state != scope_pkg::ACQ_DONE && polls < 40) begin
			send_cmd({56'd0, scope_pkg::CMD_ACK});
			recv_reply(name, rep);
			rw.raw = rep;
			polls++;
		end
		if (rw.status.acq_state != scope_pkg::ACQ_DONE) begin
			errors++;
			$display("%s: engine never reached the done state", name);
		end else if (rep !== exp) begin
			report_mismatch(name, exp, rep);
		end
	endtask

	task automatic apply_raw(input logic [239:0] v);
		@(negedge clk);
		i_raw_samples = v;
	endtask

	// ------------------------------
	// test sequence
	initial begin
		logic [31:0]        rep;
		logic [239:0]       base;
		logic [239:0]       below;
		logic [239:0]       qraw;
		logic [239:0]       ra;
		logic [239:0]       rb;
		logic [9:0]         m;
		logic [9:0]         hit;
		logic signed [11:0] lo;
		logic signed [11:0] hi;
		int                 t0;
		bit                 fires;
		bit                 stray;

		void'($urandom(36));
		rstn          = 1'b0;
		i_rx_tvalid   = 1'b0;
		i_rx_tdata    = '0;
		i_tx_tready   = 1'b0;
		i_raw_samples = '0;
		i_ext_trig    = 1'b0;
		repeat (2) @(negedge clk);
		rstn = 1'b1;

		// version reply under back-pressure
		for (int i = 0; i < 4; i++) begin
			send_cmd({48'd0, 8'd0, scope_pkg::CMD_INFO});
			recv_reply("version", rep);
			if (rep !== 32'd18) report_mismatch("version", 32'd18, rep);
		end
		send_cmd({48'd0, 8'd3, scope_pkg::CMD_INFO});          // other sub-code reads 0
		recv_reply("version subcode", rep);
		if (rep !== 32'd0) report_mismatch("version subcode", 32'd0, rep);

		// unknown code, silent, then back to normal
		stray = 0;
		send_cmd({56'd0, 8'h55});
		repeat (12) begin
			@(negedge clk);
			if (o_tx_tvalid) stray = 1;
		end
		if (stray) begin
			errors++;
			$display("unknown command: a reply beat appeared");
		end
		if (!o_rx_tready) begin
			errors++;
			$display("unknown command: decoder not ready for the next command");
		end
		send_cmd({48'd0, 8'd0, scope_pkg::CMD_INFO});
		recv_reply("after unknown", rep);
		if (rep !== 32'd18) report_mismatch("after unknown", 32'd18, rep);

		// immediate trigger, no pulse out
		t0 = trig_cnt;
		arm_cmd("immediate arm", scope_pkg::TRIG_NOW, 1'b0, 16'd4, scope_pkg::ACQ_READY);
		poll_done("immediate done", status_word(8'(ev + 1), 16'd0, scope_pkg::ACQ_DONE));
		ev++;
		ack_check("immediate ack", status_word(8'(ev), 16'd0, scope_pkg::ACQ_READY));
		if (trig_cnt != t0) report_mismatch("immediate trig out", t0, trig_cnt);

		// rising on ch0, thresholds 456 / 584, tot 2
		hi    = thr_calc(160, 4, 1);
		base  = fill_lanes(-12'sd500, -12'sd500, '0);          // conditioned 500, in between
		below = fill_lanes(12'sd0, 12'sd0, '0);
		set_trig("rise setup", 8'd160, 8'd4, 8'd2, 1'b0);
		apply_raw(base);
		arm_cmd("rise arm", scope_pkg::TRIG_RISE, 1'b0, 16'd16, scope_pkg::ACQ_READY);
		t0   = trig_cnt;
		qraw = fill_lanes(-12'sd500, -12'sd1000, '1);
		apply_raw(below);
		repeat (2) apply_raw(qraw);                            // too short for tot 2
		apply_raw(base);
		repeat (4) @(negedge clk);
		if (trig_cnt != t0) report_mismatch("rise short burst", t0, trig_cnt);
		ack_check("rise rearmed", status_word(8'(ev), 16'd0, scope_pkg::ACQ_RISE_ARM));
		m    = 10'($urandom_range(1023, 1));
		qraw = fill_lanes(-12'sd500, -12'sd1000, {10'd0, m});
		hit  = qual_mask(qraw, 1'b0, 1'b0, hi, 1'b0);
		apply_raw(below);
		repeat (3) apply_raw(qraw);
		apply_raw(base);
		repeat (4) @(negedge clk);
		if (trig_cnt != t0 + 1) report_mismatch("rise trig out", t0 + 1, trig_cnt);
		poll_done("rise done", status_word(8'(ev + 1), {6'd0, hit}, scope_pkg::ACQ_DONE));
		ev++;

		// falling on ch1, thresholds -152 / 168, tot 0, dual then single
		lo = thr_calc(128, 10, 0);
		hi = thr_calc(128, 10, 1);
		set_trig("fall setup", 8'd128, 8'd10, 8'd0, 1'b1);
		apply_raw(below);
		ra = fill_lanes(12'sd0, 12'sd1000, 20'hffc00);
		rb = fill_lanes(12'sd0, -12'sd1000, 20'hffc00);
		for (int d = 1; d >= 0; d--) begin
			arm_cmd("fall arm", scope_pkg::TRIG_FALL, d[0], 16'd8, scope_pkg::ACQ_READY);
			t0    = trig_cnt;
			hit   = qual_mask(rb, d[0], 1'b1, lo, 1'b1);
			fires = (|qual_mask(ra, d[0], 1'b1, hi, 1'b0)) && (|hit);
			apply_raw(ra);
			apply_raw(rb);
			apply_raw(below);
			repeat (4) @(negedge clk);
			if (trig_cnt != t0 + (fires ? 1 : 0))
				report_mismatch(d ? "fall dual" : "fall single", t0 + (fires ? 1 : 0), trig_cnt);
			if (fires) begin
				poll_done("fall done", status_word(8'(ev + 1), {6'd0, hit}, scope_pkg::ACQ_DONE));
				ev++;
			end else begin
				// retype drops the armed engine back to ready
				arm_cmd("fall cleanup", scope_pkg::TRIG_NOW, 1'b0, 16'd1, scope_pkg::ACQ_FALL_ARM);
			end
		end

		// external trigger
		arm_cmd("ext arm", scope_pkg::TRIG_EXT, 1'b0, 16'd32, scope_pkg::ACQ_READY);
		t0 = trig_cnt;
		repeat (6) @(negedge clk);
		ack_check("ext waiting", status_word(8'(ev), 16'd0, scope_pkg::ACQ_EXT_WAIT));
		if (trig_cnt != t0) report_mismatch("ext early", t0, trig_cnt);
		@(negedge clk);
		i_ext_trig = 1'b1;
		@(negedge clk);
		i_ext_trig = 1'b0;
		repeat (4) @(negedge clk);
		if (trig_cnt != t0 + 1) report_mismatch("ext trig out", t0 + 1, trig_cnt);
		poll_done("ext done", status_word(8'(ev + 1), 16'd0, scope_pkg::ACQ_DONE));
		ev++;

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: design/scope_ctrl_top.sv
// scope control core, top level
// command decoder and sample conditioner side by side, feeding the trigger engine
`timescale 1ns/10ps

module scope_ctrl_top (
	input  logic        clk,
	input  logic        rstn,
	// command bytes
	input  logic        i_rx_tvalid,
	input  logic [7:0]  i_rx_tdata,
	output logic        o_rx_tready,
	// replies
	output logic        o_tx_tvalid,
	output logic [31:0] o_tx_tdata,
	output logic [3:0]  o_tx_tkeep,
	output logic        o_tx_tlast,
	input  logic        i_tx_tready,
	// adc words, lane 0..9 ch0, lane 10..19 ch1
	input  logic [scope_pkg::NUM_LANES*scope_pkg::SAMPLE_W-1:0] i_raw_samples,
	input  logic        i_ext_trig,
	output logic        o_trig_out
);

	logic signed [scope_pkg::SAMPLE_W-1:0] cond_samples [scope_pkg::NUM_LANES];

	acq_ctrl_if u_ctrl ();

	sample_conditioner u_cond (
		.clk       (clk),
		.rstn      (rstn),
		.i_raw     (i_raw_samples),
		.ctrl      (u_ctrl.conditioner),
		.o_samples (cond_samples)
	);

	cmd_decoder u_dec (
		.clk         (clk),
		.rstn        (rstn),
		.i_rx_tvalid (i_rx_tvalid),
		.i_rx_tdata  (i_rx_tdata),
		.o_rx_tready (o_rx_tready),
		.o_tx_tvalid (o_tx_tvalid),
		.o_tx_tdata  (o_tx_tdata),
		.o_tx_tkeep  (o_tx_tkeep),
		.o_tx_tlast  (o_tx_tlast),
		.i_tx_tready (i_tx_tready),
		.ctrl        (u_ctrl.decoder)
	);

	trigger_engine u_trig (
		.clk        (clk),
		.rstn       (rstn),
		.i_samples  (cond_samples),
		.i_ext_trig (i_ext_trig),
		.o_trig_out (o_trig_out),
		.ctrl       (u_ctrl.engine)
	);

endmodule

// File: design/trigger_engine.sv
// trigger engine
// one acquisition per arm: immediate, threshold with time over threshold, or external,
// then a post-trigger count and a wait for the host acknowledge
`timescale 1ns/10ps

module trigger_engine (
	input  logic                                  clk,
	input  logic                                  rstn,
	input  logic signed [scope_pkg::SAMPLE_W-1:0] i_samples [scope_pkg::NUM_LANES],
	input  logic                                  i_ext_trig,
	output logic                                  o_trig_out,
	acq_ctrl_if.engine                            ctrl
);

	scope_pkg::acq_state_e                 state;
	scope_pkg::acq_state_e                 arm_back;     // arm state of the current fire state
	logic signed [scope_pkg::SAMPLE_W-1:0] sel [scope_pkg::SAMPLES_PER_CH];
	logic [scope_pkg::SAMPLES_PER_CH-1:0]  below_lo;
	logic [scope_pkg::SAMPLES_PER_CH-1:0]  above_hi;
	logic [scope_pkg::SAMPLES_PER_CH-1:0]  qual;         // per sample, fire condition
	logic [7:0]                            fire_type;
	logic [7:0]                            tot_cnt;
	logic [15:0]                           post_cnt;
	logic [7:0]                            event_count;
	logic [15:0]                           sample_hit;
	logic                                  trig_out;

	// ------------------------------
	// compare the selected channel against both thresholds
	always_comb begin
		for (int i = 0; i < scope_pkg::SAMPLES_PER_CH; i++) begin
			sel[i]      = ctrl.trig_chan ? i_samples[scope_pkg::SAMPLES_PER_CH + i] : i_samples[i];
			below_lo[i] = sel[i] < ctrl.lower_thr;
			above_hi[i] = sel[i] > ctrl.upper_thr;
		end
	end

	// rising fires above the upper, falling below the lower
	assign qual      = (state == scope_pkg::ACQ_FALL_FIRE) ? below_lo : above_hi;
	assign fire_type = (state == scope_pkg::ACQ_FALL_FIRE) ? scope_pkg::TRIG_FALL
	                                                       : scope_pkg::TRIG_RISE;
	assign arm_back  = (state == scope_pkg::ACQ_FALL_FIRE) ? scope_pkg::ACQ_FALL_ARM
	                                                       : scope_pkg::ACQ_RISE_ARM;

	// ------------------------------
	// acquisition fsm
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= scope_pkg::ACQ_READY;
			tot_cnt     <= '0;
			post_cnt    <= '0;
			event_count <= '0;
			sample_hit  <= '0;
			trig_out    <= 1'b0;
		end else begin
			trig_out <= 1'b0;                                  // single clk pulse
			case (state)
				scope_pkg::ACQ_READY: if (ctrl.arm_pulse) begin
					sample_hit <= '0;
					tot_cnt    <= '0;
					post_cnt   <= '0;
					case (ctrl.trig_type)
						scope_pkg::TRIG_NOW:  state <= scope_pkg::ACQ_POST;   // no pulse out
						scope_pkg::TRIG_RISE: state <= scope_pkg::ACQ_RISE_ARM;
						scope_pkg::TRIG_FALL: state <= scope_pkg::ACQ_FALL_ARM;
						scope_pkg::TRIG_EXT:  state <= scope_pkg::ACQ_EXT_WAIT;
						default:              state <= scope_pkg::ACQ_READY;  // unsupported type
					endcase
				end
				scope_pkg::ACQ_RISE_ARM: begin
					if (ctrl.trig_type != scope_pkg::TRIG_RISE) state <= scope_pkg::ACQ_READY;
					else if (|below_lo) state <= scope_pkg::ACQ_RISE_FIRE; // came from below
				end
				scope_pkg::ACQ_FALL_ARM: begin
					if (ctrl.trig_type != scope_pkg::TRIG_FALL) state <= scope_pkg::ACQ_READY;
					else if (|above_hi) state <= scope_pkg::ACQ_FALL_FIRE; // came from above
				end
				scope_pkg::ACQ_RISE_FIRE,
				scope_pkg::ACQ_FALL_FIRE: begin
					if (ctrl.trig_type != fire_type) begin
						state <= scope_pkg::ACQ_READY;             // retyped while armed
					end else if (|qual) begin
						if (tot_cnt < ctrl.tot_limit) begin
							tot_cnt <= tot_cnt + 8'd1;             // still counting tot
						end else begin
							sample_hit <= 16'(qual);
							trig_out   <= 1'b1;
							post_cnt   <= '0;
							state      <= scope_pkg::ACQ_POST;
						end
					end else begin
						tot_cnt <= '0;                             // dropped out, rearm
						state   <= arm_back;
					end
				end
				scope_pkg::ACQ_EXT_WAIT: begin
					if (ctrl.trig_type != scope_pkg::TRIG_EXT) begin
						state <= scope_pkg::ACQ_READY;
					end else if (i_ext_trig) begin
						trig_out <= 1'b1;
						post_cnt <= '0;
						state    <= scope_pkg::ACQ_POST;
					end
				end
				scope_pkg::ACQ_POST: begin
					// stays post_len clks, at least one
					if ({1'b0, post_cnt} + 17'd1 >= {1'b0, ctrl.post_len}) begin
						event_count <= event_count + 8'd1;
						state       <= scope_pkg::ACQ_DONE;
					end else begin
						post_cnt <= post_cnt + 16'd1;
					end
				end
				scope_pkg::ACQ_DONE: if (ctrl.ack_pulse) state <= scope_pkg::ACQ_READY;
				default: state <= scope_pkg::ACQ_READY;
			endcase
		end
	end

	assign ctrl.acq_state   = state;
	assign ctrl.event_count = event_count;
	assign ctrl.sample_hit  = sample_hit;
	assign o_trig_out       = trig_out;

	a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
		state inside {scope_pkg::ACQ_READY, scope_pkg::ACQ_RISE_ARM, scope_pkg::ACQ_RISE_FIRE,
			scope_pkg::ACQ_FALL_ARM, scope_pkg::ACQ_FALL_FIRE, scope_pkg::ACQ_EXT_WAIT,
			scope_pkg::ACQ_POST, scope_pkg::ACQ_DONE});

	a_trig_single: assert property (@(posedge clk) disable iff (!rstn)
		o_trig_out |=> !o_trig_out);

endmodule

// File: design/cmd_decoder.sv
// command decoder
// gathers 8-byte commands from the byte stream, runs them, keeps the trigger settings
// and sends back one 32-bit reply beat per answered command
`timescale 1ns/10ps

module cmd_decoder (
	input  logic        clk,
	input  logic        rstn,
	// byte stream in
	input  logic        i_rx_tvalid,
	input  logic [7:0]  i_rx_tdata,
	output logic        o_rx_tready,
	// reply stream out
	output logic        o_tx_tvalid,
	output logic [31:0] o_tx_tdata,
	output logic [3:0]  o_tx_tkeep,
	output logic        o_tx_tlast,
	input  logic        i_tx_tready,
	acq_ctrl_if.decoder ctrl
);

	logic [1:0]                       state;
	logic [scope_pkg::CMD_CNT_W-1:0]  rx_cnt;                      // byte index in command
	logic [7:0]                       rx_buf [scope_pkg::CMD_BYTES];
	logic                             rx_rdy;
	logic                             tx_vld;
	logic                             rx_fire;
	logic                             rx_last;
	logic                             known_cmd;
	logic [scope_pkg::SAMPLE_W-1:0]   thr_lo;
	logic [scope_pkg::SAMPLE_W-1:0]   thr_hi;
	scope_pkg::reply_word_u           status_w;
	scope_pkg::reply_word_u           tx_word;

	assign rx_fire = i_rx_tvalid & rx_rdy;
	assign rx_last = rx_fire && (rx_cnt == scope_pkg::CMD_CNT_W'(scope_pkg::CMD_BYTES - 1));

	assign known_cmd = rx_buf[0] inside {scope_pkg::CMD_ACK, scope_pkg::CMD_ARM,
		scope_pkg::CMD_INFO, scope_pkg::CMD_TRIG_SET};

	// level byte1, hysteresis byte2, mapped onto the 12-bit adc scale, wraps like the adc word
	assign thr_lo = ((12'(rx_buf[1]) - 12'(rx_buf[2]) - 12'd128) << 4) + 12'd8;
	assign thr_hi = ((12'(rx_buf[1]) + 12'(rx_buf[2]) - 12'd128) << 4) + 12'd8;

	always_comb begin
		status_w.status.event_count = ctrl.event_count;
		status_w.status.sample_hit  = ctrl.sample_hit;
		status_w.status.acq_state   = ctrl.acq_state;
	end

	// ------------------------------
	// command bytes and reply word
	always_ff @(posedge clk) begin
		if (rx_fire)
			rx_buf[rx_cnt] <= i_rx_tdata;
		if (state == scope_pkg::DEC_EXEC) begin
			case (rx_buf[0])
				scope_pkg::CMD_ACK,
				scope_pkg::CMD_ARM:      tx_word <= status_w;           // state snapshot
				scope_pkg::CMD_INFO:     tx_word.raw <= (rx_buf[1] == 8'd0) ?
				                                        scope_pkg::FW_VERSION : 32'd0;
				scope_pkg::CMD_TRIG_SET: tx_word.raw <= 32'(scope_pkg::CMD_TRIG_SET); // echo
				default:                 tx_word <= tx_word;            // no reply
			endcase
		end
	end

	// ------------------------------
	// fsm and settings
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= scope_pkg::DEC_RX;
			rx_cnt         <= '0;
			rx_rdy         <= 1'b0;                 // comes up one clk after reset
			tx_vld         <= 1'b0;
			ctrl.arm_pulse <= 1'b0;
			ctrl.ack_pulse <= 1'b0;
			ctrl.trig_type <= '0;
			ctrl.dual_mode <= 1'b0;
			ctrl.post_len  <= '0;
			ctrl.lower_thr <= '0;
			ctrl.upper_thr <= '0;
			ctrl.tot_limit <= '0;
			ctrl.trig_chan <= 1'b0;
		end else begin
			ctrl.arm_pulse <= 1'b0;
			ctrl.ack_pulse <= 1'b0;
			case (state)
				scope_pkg::DEC_RX: begin
					rx_rdy <= !rx_last;
					if (rx_fire)
						rx_cnt <= rx_cnt + 1'b1;          // wraps to 0 after byte 7
					if (rx_last)
						state <= scope_pkg::DEC_EXEC;
				end
				scope_pkg::DEC_EXEC: begin
					case (rx_buf[0])
						scope_pkg::CMD_ACK: ctrl.ack_pulse <= 1'b1;
						scope_pkg::CMD_ARM: begin
							ctrl.trig_type <= rx_buf[1];
							ctrl.dual_mode <= rx_buf[2][0];
							ctrl.post_len  <= {rx_buf[5], rx_buf[4]};
							ctrl.arm_pulse <= 1'b1;
						end
						scope_pkg::CMD_TRIG_SET: begin
							ctrl.lower_thr <= $signed(thr_lo);
							ctrl.upper_thr <= $signed(thr_hi);
							ctrl.tot_limit <= rx_buf[5];
							ctrl.trig_chan <= rx_buf[6][0];
						end
						default: ;                            // info and unknown touch nothing
					endcase
					tx_vld <= known_cmd;
					rx_rdy <= !known_cmd;                     // unknown code, back to listening
					state  <= known_cmd ? scope_pkg::DEC_REPLY : scope_pkg::DEC_RX;
				end
				scope_pkg::DEC_REPLY: begin
					if (i_tx_tready) begin                    // beat taken
						tx_vld <= 1'b0;
						rx_rdy <= 1'b1;
						state  <= scope_pkg::DEC_RX;
					end
				end
				default: state <= scope_pkg::DEC_RX;
			endcase
		end
	end

	assign o_rx_tready = rx_rdy;
	assign o_tx_tvalid = tx_vld;
	assign o_tx_tdata  = tx_word.raw;
	assign o_tx_tkeep  = {4{tx_vld}};                // single full beat
	assign o_tx_tlast  = tx_vld;

	// reply beat holds until taken
	a_tx_hold: assert property (@(posedge clk) disable iff (!rstn)
		o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata));

endmodule

// File: design/sample_conditioner.sv
// adc sample conditioner
// registers the raw words and inverts them with saturation, channel 1 stays upright in dual mode
`timescale 1ns/10ps

module sample_conditioner (
	input  logic                                   clk,
	input  logic                                   rstn,
	input  logic [scope_pkg::NUM_LANES-1:0][scope_pkg::SAMPLE_W-1:0] i_raw,
	acq_ctrl_if.conditioner                        ctrl,
	output logic signed [scope_pkg::SAMPLE_W-1:0]  o_samples [scope_pkg::NUM_LANES]
);

	// -2048 would wrap back onto itself, clamp to +2047
	function automatic logic signed [scope_pkg::SAMPLE_W-1:0] neg_sat(
		input logic signed [scope_pkg::SAMPLE_W-1:0] v
	);
		if (v == scope_pkg::SAMPLE_MIN) return scope_pkg::SAMPLE_MAX;
		return -v;
	endfunction

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_samples <= '{default: '0};
		end else begin
			for (int i = 0; i < scope_pkg::NUM_LANES; i++) begin
				if (i < scope_pkg::SAMPLES_PER_CH || !ctrl.dual_mode) // ch0 always, ch1 single only
					o_samples[i] <= neg_sat($signed(i_raw[i]));
				else
					o_samples[i] <= $signed(i_raw[i]);             // dual mode, ch1 as is
			end
		end
	end

	// inverted lanes never show the unreachable minimum
	for (genvar g = 0; g < scope_pkg::NUM_LANES; g++) begin : g_sat_chk
		if (g < scope_pkg::SAMPLES_PER_CH) begin : g_ch0
			a_ch0_no_min: assert property (@(posedge clk) disable iff (!rstn)
				o_samples[g] != scope_pkg::SAMPLE_MIN);
		end else begin : g_ch1
			a_ch1_no_min: assert property (@(posedge clk) disable iff (!rstn)
				!$past(ctrl.dual_mode) |-> o_samples[g] != scope_pkg::SAMPLE_MIN);
		end
	end

endmodule

// File: design/acq_ctrl_if.sv
// acquisition control bundle
// settings and strobes from the command decoder, status back from the trigger engine
`timescale 1ns/10ps

interface acq_ctrl_if;

	// written by the decoder
	logic [7:0]                              trig_type;
	logic                                    dual_mode;    // 1 = channel 1 not inverted
	logic [15:0]                             post_len;
	logic signed [scope_pkg::SAMPLE_W-1:0]   lower_thr;
	logic signed [scope_pkg::SAMPLE_W-1:0]   upper_thr;
	logic [7:0]                              tot_limit;
	logic                                    trig_chan;
	logic                                    arm_pulse;    // one clk
	logic                                    ack_pulse;    // one clk

	// written by the engine
	scope_pkg::acq_state_e                   acq_state;
	logic [7:0]                              event_count;
	logic [15:0]                             sample_hit;

	modport decoder (
		output trig_type, dual_mode, post_len, lower_thr, upper_thr, tot_limit, trig_chan,
		output arm_pulse, ack_pulse,
		input  acq_state, event_count, sample_hit
	);

	modport engine (
		input  trig_type, post_len, lower_thr, upper_thr, tot_limit, trig_chan,
		input  arm_pulse, ack_pulse,
		output acq_state, event_count, sample_hit
	);

	modport conditioner (input dual_mode);

endinterface

// File: design/scope_pkg.sv
// scope control package
// widths, command and trigger codes, state codes and the reply word layout
package scope_pkg;

	// ------------------------------
	// sample geometry
	localparam int SAMPLE_W       = 12;                       // bits per adc sample
	localparam int SAMPLES_PER_CH = 10;                       // samples per channel per clk
	localparam int NUM_CH         = 2;
	localparam int NUM_LANES      = NUM_CH * SAMPLES_PER_CH;  // 20 lanes in total

	localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 12'sh7ff; // +2047
	localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 12'sh800; // -2048, has no positive twin

	// ------------------------------
	// command stream
	localparam int CMD_BYTES = 8;                     // fixed length commands
	localparam int CMD_CNT_W = $clog2(CMD_BYTES);

	localparam logic [31:0] FW_VERSION = 32'd18;

	localparam logic [7:0] CMD_ACK      = 8'd0;       // acknowledge event
	localparam logic [7:0] CMD_ARM      = 8'd1;       // set trigger type, mode, length and arm
	localparam logic [7:0] CMD_INFO     = 8'd2;       // firmware version
	localparam logic [7:0] CMD_TRIG_SET = 8'd8;       // thresholds, tot, trigger channel

	localparam logic [7:0] TRIG_NOW  = 8'd0;
	localparam logic [7:0] TRIG_RISE = 8'd1;
	localparam logic [7:0] TRIG_FALL = 8'd2;
	localparam logic [7:0] TRIG_EXT  = 8'd3;

	// decoder fsm
	localparam logic [1:0] DEC_RX    = 2'd0;          // collecting bytes
	localparam logic [1:0] DEC_EXEC  = 2'd1;          // one cycle, runs the command
	localparam logic [1:0] DEC_REPLY = 2'd2;          // holding the reply beat

	// ------------------------------
	// acquisition states, codes kept from the board firmware
	typedef enum logic [7:0] {
		ACQ_READY     = 8'd0,
		ACQ_RISE_ARM  = 8'd1,
		ACQ_RISE_FIRE = 8'd2,
		ACQ_FALL_ARM  = 8'd3,
		ACQ_FALL_FIRE = 8'd4,
		ACQ_EXT_WAIT  = 8'd5,
		ACQ_POST      = 8'd250,
		ACQ_DONE      = 8'd251
	} acq_state_e;

	typedef struct packed {
		logic [7:0]  event_count;  // msb
		logic [15:0] sample_hit;
		logic [7:0]  acq_state;    // lsb
	} reply_status_t;

	// one 32-bit reply beat, either status or a plain number
	typedef union packed {
		reply_status_t status;
		logic [31:0]   raw;
	} reply_word_u;

endpackage
